/* hdl/frame_pkg.sv */
package frame_pkg;

   // data widths
   localparam int BYTE_W = 8;
   localparam int WORD_W = 32;
   localparam int LANES = WORD_W / BYTE_W;

   // buffer geometry
   localparam int BUF_BYTES = 256;
   localparam int BYTE_ADDR_W = 8;
   localparam int WORD_ADDR_W = 6;

   // length in bytes, wide enough to hold a full buffer
   localparam int LEN_W = 9;
   // word count of a frame, 0 to 64
   localparam int WORD_CNT_W = 7;
   // valid lane count, 1 to 4
   localparam int LANE_CNT_W = 3;

   // FLUSH lets the in-flight reads drain out of the pipeline
   typedef enum logic [1:0] {
      IDLE,
      DRAIN,
      FLUSH
   } drain_state_e;

   typedef struct packed {
      logic              valid;
      logic [BYTE_W-1:0] data;
      logic              frame_end;
   } byte_in_t;

   typedef struct packed {
      logic                   en;
      logic [WORD_ADDR_W-1:0] addr;
      logic                   last;
      logic [LANE_CNT_W-1:0]  lanes;
   } rd_req_t;

   typedef struct packed {
      logic              valid;
      logic              last;
      logic [WORD_W-1:0] data;
   } word_out_t;

endpackage

/* hdl/sym_2p_ram.sv */
`timescale 1ns/1ps

module sym_2p_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 6
) (
   input  logic              clk_i,
   // write port
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   // read port
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read data holds while r_en_i is low
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* hdl/asym_2p_ram.sv */
`timescale 1ns/1ps

// addresses count units of the narrower port, which is the write side here
// built from MAX_W / MIN_W symmetric blocks of MIN_W bits each
module asym_2p_ram #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  logic                clk_i,
   // write port
   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   input  logic [ADDR_W-1:0]   w_addr_i,
   // read port
   input  logic                r_en_i,
   input  logic [ADDR_W-1:0]   r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o
);

   localparam int MAX_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MIN_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int N = MAX_W / MIN_W;
   localparam int N_W = $clog2(N);
   localparam int BLK_AW = ADDR_W - N_W;

   logic [N-1:0]     blk_w_en;
   logic [MIN_W-1:0] blk_w_data [N];
   logic [MIN_W-1:0] blk_r_data [N];

   // low address bits pick the block, the rest index inside it
   for (genvar i = 0; i < N; i++) begin : g_blk
      sym_2p_ram #(
         .DATA_W (MIN_W),
         .ADDR_W (BLK_AW)
      ) i_sym_2p_ram (
         .clk_i    (clk_i),
         .w_en_i   (blk_w_en[i]),
         .w_addr_i (w_addr_i[ADDR_W-1:N_W]),
         .w_data_i (blk_w_data[i]),
         .r_en_i   (r_en_i),
         .r_addr_i (r_addr_i[ADDR_W-1:N_W]),
         .r_data_o (blk_r_data[i])
      );
   end

   if (W_DATA_W < R_DATA_W) begin : g_wr_narrow
      // serial write into one block, parallel read in lane order
      for (genvar i = 0; i < N; i++) begin : g_lane
         assign blk_w_en[i] = w_en_i && (w_addr_i[N_W-1:0] == N_W'(i));
         assign blk_w_data[i] = w_data_i;
         assign r_data_o[i*MIN_W +: MIN_W] = blk_r_data[i];
      end
   end else if (W_DATA_W > R_DATA_W) begin : g_rd_narrow
      logic [N_W-1:0] r_sel_q;

      // block select follows the registered read data by one cycle
      always_ff @(posedge clk_i) begin
         if (r_en_i) begin
            r_sel_q <= r_addr_i[N_W-1:0];
         end
      end

      for (genvar i = 0; i < N; i++) begin : g_lane
         assign blk_w_en[i] = w_en_i;
         assign blk_w_data[i] = w_data_i[i*MIN_W +: MIN_W];
      end

      assign r_data_o = blk_r_data[r_sel_q];
   end else begin : g_equal
      assign blk_w_en[0] = w_en_i;
      assign blk_w_data[0] = w_data_i;
      assign r_data_o = blk_r_data[0];
   end

endmodule

/* hdl/buffer_pointers.sv */
`timescale 1ns/1ps

module buffer_pointers (
   input  logic                               clk_i,
   input  logic                               reset_i,
   input  frame_pkg::byte_in_t                in_i,
   input  logic                               idle_i,
   input  logic                               next_word_i,
   input  logic                               drain_done_i,
   output logic                               w_en_o,
   output logic [frame_pkg::BYTE_ADDR_W-1:0]  w_addr_o,
   output logic [frame_pkg::LEN_W-1:0]        frame_len_o,
   output logic [frame_pkg::WORD_ADDR_W-1:0]  rd_addr_o,
   output logic                               overflow_o
);

   import frame_pkg::*;

   logic [LEN_W-1:0]       wr_ptr_q;
   logic [WORD_ADDR_W-1:0] rd_ptr_q;
   logic                   ovf_q;
   logic                   offered;
   logic                   full;

   // bytes only count while no drain is running
   assign offered = in_i.valid && idle_i;
   assign full = (wr_ptr_q == LEN_W'(BUF_BYTES));

   assign w_en_o = offered && !full;
   assign w_addr_o = wr_ptr_q[BYTE_ADDR_W-1:0];

   // includes a byte accepted in the frame end cycle
   assign frame_len_o = wr_ptr_q + LEN_W'(w_en_o);

   assign rd_addr_o = rd_ptr_q;
   assign overflow_o = ovf_q;

   always_ff @(posedge clk_i) begin
      if (reset_i || drain_done_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         ovf_q <= 1'b0;
      end else begin
         if (w_en_o) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         // sticky until the drain completes
         if (offered && full) begin
            ovf_q <= 1'b1;
         end
         if (next_word_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

endmodule

/* hdl/drain_fsm.sv */
`timescale 1ns/1ps

module drain_fsm (
   input  logic                              clk_i,
   input  logic                              reset_i,
   input  logic                              frame_end_i,
   input  logic [frame_pkg::LEN_W-1:0]       frame_len_i,
   input  logic [frame_pkg::WORD_ADDR_W-1:0] rd_addr_i,
   output frame_pkg::rd_req_t                req_o,
   output logic                              next_word_o,
   output logic                              idle_o,
   output logic                              drain_done_o,
   output logic                              busy_o
);

   import frame_pkg::*;

   drain_state_e          state_q;
   drain_state_e          state_d;
   logic [WORD_CNT_W-1:0] words_q;
   logic [LANE_CNT_W-1:0] lanes_q;
   logic                  tail_q;
   logic                  start;
   logic                  issue;
   logic                  last_word;

   assign start = frame_end_i && idle_o;
   assign issue = (state_q == DRAIN) && (words_q != '0);
   assign last_word = (WORD_CNT_W'(rd_addr_i) + WORD_CNT_W'(1)) == words_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (start) begin
               state_d = DRAIN;
            end
         end
         DRAIN: begin
            // empty frame leaves at once
            if (!issue || last_word) begin
               state_d = FLUSH;
            end
         end
         FLUSH: state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= IDLE;
         tail_q <= 1'b0;
      end else begin
         state_q <= state_d;
         // last word still in the output register
         tail_q <= (state_q == FLUSH);
      end
   end

   // word count and lanes of the final word
   always_ff @(posedge clk_i) begin
      if (start) begin
         words_q <= WORD_CNT_W'((frame_len_i + LEN_W'(LANES - 1)) >> $clog2(LANES));
         lanes_q <= (frame_len_i[1:0] == 2'd0) ? LANE_CNT_W'(LANES)
                                               : LANE_CNT_W'(frame_len_i[1:0]);
      end
   end

   assign req_o.en = issue;
   assign req_o.addr = rd_addr_i;
   assign req_o.last = issue && last_word;
   assign req_o.lanes = req_o.last ? lanes_q : LANE_CNT_W'(LANES);

   assign next_word_o = issue;
   assign busy_o = (state_q != IDLE) || tail_q;
   assign idle_o = !busy_o;
   assign drain_done_o = tail_q;

endmodule

/* hdl/word_output_stage.sv */
`timescale 1ns/1ps

module word_output_stage (
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  frame_pkg::rd_req_t           req_i,
   input  logic [frame_pkg::WORD_W-1:0] rd_data_i,
   output frame_pkg::word_out_t         out_o
);

   import frame_pkg::*;

   rd_req_t           tag_q;
   logic [WORD_W-1:0] masked;
   logic              out_valid_q;
   logic              out_last_q;
   logic [WORD_W-1:0] out_data_q;

   // tag lines up with the RAM data one cycle later
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         tag_q <= '0;
      end else begin
         tag_q <= req_i;
      end
   end

   // lanes never written in this frame read as zero
   always_comb begin
      for (int l = 0; l < LANES; l++) begin
         if (LANE_CNT_W'(l) < tag_q.lanes) begin
            masked[l*BYTE_W +: BYTE_W] = rd_data_i[l*BYTE_W +: BYTE_W];
         end else begin
            masked[l*BYTE_W +: BYTE_W] = '0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         out_valid_q <= 1'b0;
         out_last_q <= 1'b0;
      end else begin
         out_valid_q <= tag_q.en;
         out_last_q <= tag_q.last;
      end
   end

   always_ff @(posedge clk_i) begin
      if (tag_q.en) begin
         out_data_q <= masked;
      end
   end

   assign out_o = '{valid: out_valid_q, last: out_last_q, data: out_data_q};

endmodule

/* hdl/frame_packer_top.sv */
`timescale 1ns/1ps

module frame_packer_top (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  frame_pkg::byte_in_t  in_i,
   output frame_pkg::word_out_t out_o,
   output logic                 busy_o,
   output logic                 overflow_o
);

   import frame_pkg::*;

   logic                   w_en;
   logic [BYTE_ADDR_W-1:0] w_addr;
   logic [LEN_W-1:0]       frame_len;
   logic [WORD_ADDR_W-1:0] rd_addr;
   logic                   idle;
   logic                   next_word;
   logic                   drain_done;
   rd_req_t                rd_req;
   logic [WORD_W-1:0]      rd_data;

   buffer_pointers i_buffer_pointers (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .in_i         (in_i),
      .idle_i       (idle),
      .next_word_i  (next_word),
      .drain_done_i (drain_done),
      .w_en_o       (w_en),
      .w_addr_o     (w_addr),
      .frame_len_o  (frame_len),
      .rd_addr_o    (rd_addr),
      .overflow_o   (overflow_o)
   );

   drain_fsm i_drain_fsm (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .frame_end_i  (in_i.frame_end),
      .frame_len_i  (frame_len),
      .rd_addr_i    (rd_addr),
      .req_o        (rd_req),
      .next_word_o  (next_word),
      .idle_o       (idle),
      .drain_done_o (drain_done),
      .busy_o       (busy_o)
   );

   // byte write, word read; read address padded to byte units
   asym_2p_ram #(
      .W_DATA_W (BYTE_W),
      .R_DATA_W (WORD_W),
      .ADDR_W   (BYTE_ADDR_W)
   ) i_asym_2p_ram (
      .clk_i    (clk_i),
      .w_en_i   (w_en),
      .w_data_i (in_i.data),
      .w_addr_i (w_addr),
      .r_en_i   (rd_req.en),
      .r_addr_i ({rd_req.addr, {(BYTE_ADDR_W - WORD_ADDR_W){1'b0}}}),
      .r_data_o (rd_data)
   );

   word_output_stage i_word_output_stage (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_i     (rd_req),
      .rd_data_i (rd_data),
      .out_o     (out_o)
   );

endmodule

/* sim/frame_packer_assertions.sv */
`timescale 1ns/1ps

module frame_packer_assertions (
   input logic                 clk_i,
   input logic                 reset_i,
   input frame_pkg::word_out_t out_i,
   input logic                 busy_i,
   input logic                 overflow_i
);

   last_has_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      out_i.last |-> out_i.valid)
      else $error("out_o.last high without out_o.valid");

   // state comes out of reset as IDLE
   reset_clears_busy: assert property (@(posedge clk_i) reset_i |=> !busy_i)
      else $error("busy_o high in the cycle after reset");

   valid_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
      out_i.valid |-> busy_i)
      else $error("out_o.valid high while busy_o is low");

   // sticky flag clears with the end of the drain
   overflow_falls_with_busy: assert property (@(posedge clk_i) disable iff (reset_i)
      $fell(overflow_i) |-> $fell(busy_i))
      else $error("overflow_o fell while busy_o did not");

endmodule

bind frame_packer_top frame_packer_assertions i_frame_packer_assertions (
   .clk_i      (clk_i),
   .reset_i    (reset_i),
   .out_i      (out_o),
   .busy_i     (busy_o),
   .overflow_i (overflow_o)
);

/* sim/frame_packer_tb.sv */
`timescale 1ns/1ps

module frame_packer_tb;

   import frame_pkg::*;

   localparam int HALF_PERIOD = 2;
   localparam int CLK_PERIOD = 2 * HALF_PERIOD;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_TESTS = 6;
   localparam int RAND_FRAMES = 6;
   // upper bound of bytes strobed over all tests
   localparam int TOTAL_BYTES = 8 + 5 + RAND_FRAMES * 64 + 260 + 8 + 2 + 4;
   localparam int WAIT_LIMIT = BUF_BYTES / LANES + 16;

   logic        clk_i = 1'b0;
   logic        reset_i;
   byte_in_t    in_byte;
   word_out_t   out_word;
   logic        busy;
   logic        overflow;
   logic [31:0] lfsr_q = 32'h44fd;
   int          cycle = 0;
   int          errors = 0;
   int          checks = 0;
   int          fe_cycle;
   logic        ovf_at_end;
   logic [7:0]  byte_q[$];
   logic [31:0] exp_data[$];
   logic        exp_last[$];
   logic [31:0] got_data[$];
   logic        got_last[$];
   int          got_cycle[$];

   frame_packer_top i_frame_packer_top (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .in_i       (in_byte),
      .out_o      (out_word),
      .busy_o     (busy),
      .overflow_o (overflow)
   );

   always #HALF_PERIOD clk_i = ~clk_i;

   // word monitor, also counts cycles
   always @(posedge clk_i) begin
      cycle <= cycle + 1;
      if (!reset_i && out_word.valid) begin
         got_data.push_back(out_word.data);
         got_last.push_back(out_word.last);
         got_cycle.push_back(cycle);
      end
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error: time %0t, %s: got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic drive(input logic valid, input logic [7:0] data, input logic frame_end);
      @(posedge clk_i);
      in_byte <= '{valid: valid, data: data, frame_end: frame_end};
   endtask

   // byte b goes to word b/4, lane b mod 4, bytes past the buffer are lost
   task automatic push_expected();
      int n;
      int words;
      logic [31:0] w;
      n = (byte_q.size() > BUF_BYTES) ? BUF_BYTES : byte_q.size();
      words = (n + LANES - 1) / LANES;
      for (int i = 0; i < words; i++) begin
         w = '0;
         for (int l = 0; l < LANES; l++) begin
            if (i * LANES + l < n) begin
               w[l*BYTE_W +: BYTE_W] = byte_q[i * LANES + l];
            end
         end
         exp_data.push_back(w);
         exp_last.push_back(i == words - 1);
      end
   endtask

   // frame end rides on the last byte when merge_end is set
   task automatic send_frame(input logic merge_end);
      int n;
      n = byte_q.size();
      for (int i = 0; i < n; i++) begin
         drive(1'b1, byte_q[i], merge_end && (i == n - 1));
      end
      if (!(merge_end && n > 0)) begin
         drive(1'b0, 8'h00, 1'b1);
      end
      fe_cycle = cycle;
      ovf_at_end = overflow;
   endtask

   task automatic finish_frame();
      int n;
      drive(1'b0, 8'h00, 1'b0);
      n = 0;
      while (!busy && n < WAIT_LIMIT) begin
         @(posedge clk_i);
         n++;
      end
      if (!busy) begin
         errors++;
         $display("timeout: busy_o never went high after the frame end");
      end
      n = 0;
      while (busy && n < WAIT_LIMIT) begin
         @(posedge clk_i);
         n++;
      end
      if (busy) begin
         errors++;
         $display("timeout: busy_o stayed high, the drain never finished");
      end
   endtask

   task automatic compare_frame();
      check("word count", got_data.size(), exp_data.size());
      for (int i = 0; i < got_data.size() && i < exp_data.size(); i++) begin
         check("out_o.data", got_data[i], exp_data[i]);
         check("out_o.last", 32'(got_last[i]), 32'(exp_last[i]));
      end
      got_data.delete();
      got_last.delete();
      got_cycle.delete();
      exp_data.delete();
      exp_last.delete();
   endtask

   task automatic run_frame(input int len, input logic merge_end);
      byte_q.delete();
      for (int i = 0; i < len; i++) begin
         byte_q.push_back(8'(rand_bits(8)));
      end
      push_expected();
      send_frame(merge_end);
      finish_frame();
   endtask

   task automatic test_two_words();
      int e0;
      e0 = errors;
      byte_q.delete();
      for (int i = 0; i < 8; i++) begin
         byte_q.push_back(8'(8'h11 * (i + 1)));
      end
      push_expected();
      send_frame(1'b0);
      finish_frame();
      // word in F+3 is seen on that cycle's closing edge
      if (got_cycle.size() > 0) begin
         check("first word latency", 32'(got_cycle[0] - fe_cycle), 32'd4);
      end
      compare_frame();
      $display("two_words: %0d errors", errors - e0);
   endtask

   task automatic test_partial_word();
      int e0;
      e0 = errors;
      run_frame(5, 1'b0);
      if (got_data.size() > 1) begin
         check("out_o.data[31:8]", 32'(got_data[1][31:8]), 32'd0);
      end
      compare_frame();
      $display("partial_word: %0d errors", errors - e0);
   endtask

   task automatic test_empty_frame();
      int e0;
      e0 = errors;
      run_frame(0, 1'b0);
      compare_frame();
      $display("empty_frame: %0d errors", errors - e0);
   endtask

   task automatic test_random_frames();
      int e0;
      int len;
      e0 = errors;
      for (int f = 0; f < RAND_FRAMES; f++) begin
         len = 1 + int'(rand_bits(6));
         run_frame(len, rand_bits(1) == 1);
         compare_frame();
      end
      $display("random_frames: %0d errors", errors - e0);
   endtask

   task automatic test_overflow();
      int e0;
      e0 = errors;
      run_frame(260, 1'b0);
      check("overflow_o before frame end", 32'(ovf_at_end), 32'd1);
      check("overflow_o after drain", 32'(overflow), 32'd0);
      compare_frame();
      $display("overflow: %0d errors", errors - e0);
   endtask

   task automatic test_busy_bytes();
      int e0;
      e0 = errors;
      byte_q.delete();
      for (int i = 0; i < 8; i++) begin
         byte_q.push_back(8'(rand_bits(8)));
      end
      push_expected();
      send_frame(1'b0);
      // strobes inside the two DRAIN cycles
      drive(1'b1, 8'hee, 1'b0);
      drive(1'b1, 8'hdd, 1'b0);
      finish_frame();
      compare_frame();
      run_frame(4, 1'b0);
      compare_frame();
      $display("busy_bytes: %0d errors", errors - e0);
   endtask

   initial begin
      reset_i = 1'b1;
      in_byte = '0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      reset_i <= 1'b0;
      test_two_words();
      test_partial_word();
      test_empty_frame();
      test_random_frames();
      test_overflow();
      test_busy_bytes();
      $display("tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      #((TOTAL_BYTES + 50 * NUM_TESTS + RESET_CYCLES) * CLK_PERIOD);
      $display("watchdog: the run did not finish in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* build.f */
hdl/frame_pkg.sv
hdl/sym_2p_ram.sv
hdl/asym_2p_ram.sv
hdl/buffer_pointers.sv
hdl/drain_fsm.sv
hdl/word_output_stage.sv
hdl/frame_packer_top.sv
sim/frame_packer_assertions.sv
sim/frame_packer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frame_packer_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
